/* verilog/symtag_pkg.sv */
package symtag_pkg;

    // channel word layout
    localparam int NUM_CHANNELS = 8;
    localparam int SAMPLE_WIDTH = 8;
    localparam int SYM_WIDTH    = 3;
    localparam int NUM_VITERBIS = 4;

    // tag sits above the packed symbols
    localparam int SYMS_WIDTH = NUM_CHANNELS * SYM_WIDTH;
    localparam int WORD_WIDTH = SYMS_WIDTH + NUM_VITERBIS;

    // clock crossing buffer
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // register port
    localparam int CFG_AW = 2;
    localparam int CFG_DW = 8;

    localparam logic [CFG_AW-1:0] ADDR_SHIFT     = 2'd0;
    localparam logic [CFG_AW-1:0] ADDR_LANE_MASK = 2'd1;
    localparam logic [CFG_AW-1:0] ADDR_STATUS    = 2'd2;

    // all lanes enabled out of reset
    localparam logic [NUM_VITERBIS-1:0] LANE_MASK_RESET = 4'hF;

endpackage

/* verilog/symtag_wr_if.sv */
`timescale 1ns/1ps

interface symtag_wr_if;
    import symtag_pkg::*;

    // i_clk domain
    logic                    push;
    logic [SYMS_WIDTH-1:0]   syms;
    logic [NUM_VITERBIS-1:0] tag;
    logic                    full;

    modport producer (
        output push,
        output syms,
        output tag,
        input  full
    );

    modport fifo (
        input  push,
        input  syms,
        input  tag,
        output full
    );

endinterface

/* verilog/symtag_rd_if.sv */
`timescale 1ns/1ps

interface symtag_rd_if;
    import symtag_pkg::*;

    // o_clk domain
    logic                    pop;
    logic [SYMS_WIDTH-1:0]   syms;
    logic [NUM_VITERBIS-1:0] tag;
    logic                    empty;

    modport fifo (
        input  pop,
        output syms,
        output tag,
        output empty
    );

    modport consumer (
        output pop,
        input  syms,
        input  tag,
        input  empty
    );

endinterface

/* verilog/rx_cfg_regs.sv */
`timescale 1ns/1ps

module rx_cfg_regs (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_cfg_we,
    input  logic [symtag_pkg::CFG_AW-1:0]       i_cfg_addr,
    input  logic [symtag_pkg::CFG_DW-1:0]       i_cfg_wdata,
    output logic [symtag_pkg::CFG_DW-1:0]       o_cfg_rdata,
    input  logic                                i_overflow_evt,
    output logic [2:0]                          o_shift,
    output logic [symtag_pkg::NUM_VITERBIS-1:0] o_lane_mask
);
    import symtag_pkg::*;

    logic [2:0]              shift_q;
    logic [NUM_VITERBIS-1:0] lane_mask_q;
    logic                    overflow_q;
    logic                    status_clr;

    assign status_clr = i_cfg_we && (i_cfg_addr == ADDR_STATUS) && i_cfg_wdata[0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            shift_q     <= 3'd0;
            lane_mask_q <= LANE_MASK_RESET;
            overflow_q  <= 1'b0;
        end else begin
            if (i_cfg_we && (i_cfg_addr == ADDR_SHIFT)) begin
                shift_q <= i_cfg_wdata[2:0];
            end
            if (i_cfg_we && (i_cfg_addr == ADDR_LANE_MASK)) begin
                lane_mask_q <= i_cfg_wdata[NUM_VITERBIS-1:0];
            end
            // sticky, a fresh event beats a clear
            if (i_overflow_evt) begin
                overflow_q <= 1'b1;
            end else if (status_clr) begin
                overflow_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (i_cfg_addr)
            ADDR_SHIFT:     o_cfg_rdata = {{(CFG_DW-3){1'b0}}, shift_q};
            ADDR_LANE_MASK: o_cfg_rdata = {{(CFG_DW-NUM_VITERBIS){1'b0}}, lane_mask_q};
            ADDR_STATUS:    o_cfg_rdata = {{(CFG_DW-1){1'b0}}, overflow_q};
            default:        o_cfg_rdata = '0;
        endcase
    end

    assign o_shift     = shift_q;
    assign o_lane_mask = lane_mask_q;

endmodule

/* verilog/symbol_quantizer.sv */
`timescale 1ns/1ps

module symbol_quantizer (
    input  logic                                                    i_clk,
    input  logic                                                    i_rst,
    input  logic                                                    i_valid,
    input  logic [symtag_pkg::NUM_CHANNELS*symtag_pkg::SAMPLE_WIDTH-1:0] i_samples,
    input  logic [symtag_pkg::NUM_VITERBIS-1:0]                     i_tag,
    input  logic [2:0]                                              i_shift,
    input  logic [symtag_pkg::NUM_VITERBIS-1:0]                     i_lane_mask,
    output logic                                                    o_overflow_evt,
    symtag_wr_if.producer                                           wr
);
    import symtag_pkg::*;

    logic [SYMS_WIDTH-1:0]   quant_syms;
    logic [NUM_VITERBIS-1:0] masked_tag;
    logic                    accept;
    logic                    load;

    // clamp a shifted sample into the soft symbol range
    function automatic logic [SYM_WIDTH-1:0] sat_sym(input logic signed [SAMPLE_WIDTH-1:0] s);
        int hi;
        int lo;
        hi = (1 <<< (SYM_WIDTH - 1)) - 1;
        lo = -(1 <<< (SYM_WIDTH - 1));
        if (s > hi) begin
            sat_sym = hi[SYM_WIDTH-1:0];
        end else if (s < lo) begin
            sat_sym = lo[SYM_WIDTH-1:0];
        end else begin
            sat_sym = s[SYM_WIDTH-1:0];
        end
    endfunction

    always_comb begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            quant_syms[ch*SYM_WIDTH +: SYM_WIDTH] =
                sat_sym($signed(i_samples[ch*SAMPLE_WIDTH +: SAMPLE_WIDTH]) >>> i_shift);
        end
    end

    assign masked_tag = i_tag & i_lane_mask;

    // untagged words are dropped here without a trace
    assign accept = i_valid && (masked_tag != '0);
    assign load   = accept && !wr.full;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr.push        <= 1'b0;
            o_overflow_evt <= 1'b0;
        end else begin
            wr.push        <= load;
            o_overflow_evt <= accept && wr.full;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            wr.syms <= quant_syms;
            wr.tag  <= masked_tag;
        end
    end

endmodule

/* verilog/symtag_fifo.sv */
`timescale 1ns/1ps

module symtag_fifo (
    input  logic      i_clk,
    input  logic      o_clk,
    input  logic      i_rst,
    symtag_wr_if.fifo wr,
    symtag_rd_if.fifo rd
);
    import symtag_pkg::*;

    logic [WORD_WIDTH-1:0] mem [FIFO_DEPTH];

    // write side, i_clk
    logic [FIFO_AW:0] wbin;
    logic [FIFO_AW:0] wgray;
    logic [FIFO_AW:0] wbin_next;
    logic [FIFO_AW:0] wgray_next;
    logic [FIFO_AW:0] rq1_gray;
    logic [FIFO_AW:0] rq2_gray;

    // read side, o_clk
    logic [FIFO_AW:0] rbin;
    logic [FIFO_AW:0] rgray;
    logic [FIFO_AW:0] rbin_next;
    logic [FIFO_AW:0] rgray_next;
    logic [FIFO_AW:0] wq1_gray;
    logic [FIFO_AW:0] wq2_gray;

    assign wbin_next  = wbin + {{FIFO_AW{1'b0}}, wr.push};
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wbin  <= '0;
            wgray <= '0;
        end else begin
            wbin  <= wbin_next;
            wgray <= wgray_next;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr.push) begin
            mem[wbin[FIFO_AW-1:0]] <= {wr.tag, wr.syms};
        end
    end

    // read pointer into i_clk
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rq1_gray <= '0;
            rq2_gray <= '0;
        end else begin
            rq1_gray <= rgray;
            rq2_gray <= rq1_gray;
        end
    end

    // counts the word already on its way in, since push is one cycle behind the decision
    assign wr.full = (wgray_next == {~rq2_gray[FIFO_AW:FIFO_AW-1], rq2_gray[FIFO_AW-2:0]});

    assign rbin_next  = rbin + {{FIFO_AW{1'b0}}, rd.pop};
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge o_clk) begin
        if (i_rst) begin
            rbin  <= '0;
            rgray <= '0;
        end else begin
            rbin  <= rbin_next;
            rgray <= rgray_next;
        end
    end

    // output word register, loads on pop
    always_ff @(posedge o_clk) begin
        if (rd.pop) begin
            {rd.tag, rd.syms} <= mem[rbin[FIFO_AW-1:0]];
        end
    end

    // write pointer into o_clk
    always_ff @(posedge o_clk) begin
        if (i_rst) begin
            wq1_gray <= '0;
            wq2_gray <= '0;
        end else begin
            wq1_gray <= wgray;
            wq2_gray <= wq1_gray;
        end
    end

    assign rd.empty = (rgray == wq2_gray);

endmodule

/* verilog/lane_router.sv */
`timescale 1ns/1ps

module lane_router (
    input  logic                                o_clk,
    input  logic                                i_rst,
    symtag_rd_if.consumer                       rd,
    output logic [symtag_pkg::NUM_VITERBIS-1:0] o_lane_valid,
    output logic [symtag_pkg::SYMS_WIDTH-1:0]   o_lane_syms
);

    logic fresh;

    // lanes never stall, so drain as soon as anything is there
    assign rd.pop = ~rd.empty;

    // word register holds a new entry for one cycle after each pop
    always_ff @(posedge o_clk) begin
        if (i_rst) begin
            fresh <= 1'b0;
        end else begin
            fresh <= rd.pop;
        end
    end

    // one pulse per tagged lane, symbols shared by all lanes
    assign o_lane_valid = fresh ? rd.tag : '0;
    assign o_lane_syms  = rd.syms;

endmodule

/* verilog/symtag_rx_top.sv */
`timescale 1ns/1ps

module symtag_rx_top (
    input  logic                                                    i_clk,
    input  logic                                                    o_clk,
    input  logic                                                    i_rst,
    input  logic                                                    i_valid,
    input  logic [symtag_pkg::NUM_CHANNELS*symtag_pkg::SAMPLE_WIDTH-1:0] i_samples,
    input  logic [symtag_pkg::NUM_VITERBIS-1:0]                     i_tag,
    input  logic                                                    i_cfg_we,
    input  logic [symtag_pkg::CFG_AW-1:0]                           i_cfg_addr,
    input  logic [symtag_pkg::CFG_DW-1:0]                           i_cfg_wdata,
    output logic [symtag_pkg::CFG_DW-1:0]                           o_cfg_rdata,
    output logic [symtag_pkg::NUM_VITERBIS-1:0]                     o_lane_valid,
    output logic [symtag_pkg::SYMS_WIDTH-1:0]                       o_lane_syms
);
    import symtag_pkg::*;

    logic [2:0]              shift;
    logic [NUM_VITERBIS-1:0] lane_mask;
    logic                    overflow_evt;

    symtag_wr_if wr_if ();
    symtag_rd_if rd_if ();

    rx_cfg_regs u_cfg (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_cfg_we       (i_cfg_we),
        .i_cfg_addr     (i_cfg_addr),
        .i_cfg_wdata    (i_cfg_wdata),
        .o_cfg_rdata    (o_cfg_rdata),
        .i_overflow_evt (overflow_evt),
        .o_shift        (shift),
        .o_lane_mask    (lane_mask)
    );

    // sampling domain
    symbol_quantizer u_quant (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_samples      (i_samples),
        .i_tag          (i_tag),
        .i_shift        (shift),
        .i_lane_mask    (lane_mask),
        .o_overflow_evt (overflow_evt),
        .wr             (wr_if.producer)
    );

    symtag_fifo u_fifo (
        .i_clk (i_clk),
        .o_clk (o_clk),
        .i_rst (i_rst),
        .wr    (wr_if.fifo),
        .rd    (rd_if.fifo)
    );

    // decoding domain
    lane_router u_router (
        .o_clk        (o_clk),
        .i_rst        (i_rst),
        .rd           (rd_if.consumer),
        .o_lane_valid (o_lane_valid),
        .o_lane_syms  (o_lane_syms)
    );

endmodule

/* sim/symtag_tb.sv */
`timescale 1ns/1ps

module symtag_tb;
    import symtag_pkg::*;

    localparam int I_PERIOD     = 100;
    localparam int O_PERIOD     = 140;
    localparam int RESET_CYCLES = 8;

    // words sent by each test
    localparam int QUANT_WORDS = 12;
    localparam int MASK_ROUNDS = 6;
    localparam int MASK_WORDS  = 8;
    localparam int ORDER_WORDS = 64;
    localparam int BURST_WORDS = 200;
    localparam int TOTAL_WORDS = 8 * QUANT_WORDS + MASK_ROUNDS * MASK_WORDS
                               + ORDER_WORDS + BURST_WORDS;
    localparam longint WATCHDOG_NS = longint'(TOTAL_WORDS) * 10 * O_PERIOD + 50_000;

    logic                                 i_clk;
    logic                                 o_clk;
    logic                                 i_rst;
    logic                                 i_valid;
    logic [NUM_CHANNELS*SAMPLE_WIDTH-1:0] i_samples;
    logic [NUM_VITERBIS-1:0]              i_tag;
    logic                                 i_cfg_we;
    logic [CFG_AW-1:0]                    i_cfg_addr;
    logic [CFG_DW-1:0]                    i_cfg_wdata;
    logic [CFG_DW-1:0]                    o_cfg_rdata;
    logic [NUM_VITERBIS-1:0]              o_lane_valid;
    logic [SYMS_WIDTH-1:0]                o_lane_syms;

    // expected words with the tag above the symbols
    logic [WORD_WIDTH-1:0]   exp_q [$];
    logic                    strict_order;
    int                      pulse_count;
    integer                  seed;
    logic [2:0]              cur_shift;
    logic [NUM_VITERBIS-1:0] cur_mask;

    symtag_rx_top UUT (
        .i_clk        (i_clk),
        .o_clk        (o_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_samples    (i_samples),
        .i_tag        (i_tag),
        .i_cfg_we     (i_cfg_we),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .o_cfg_rdata  (o_cfg_rdata),
        .o_lane_valid (o_lane_valid),
        .o_lane_syms  (o_lane_syms)
    );

    always #(I_PERIOD / 2) i_clk = ~i_clk;
    always #(O_PERIOD / 2) o_clk = ~o_clk;

    task automatic report_failure(input string what);
        $display("error: %s", what);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h expected %h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at first error");
        end
    endtask

    // shift right arithmetically, then clamp each channel to -4..3
    function automatic logic [SYMS_WIDTH-1:0] ref_quantize(
        input logic [NUM_CHANNELS*SAMPLE_WIDTH-1:0] samples, input int shift);
        logic [SYMS_WIDTH-1:0] result;
        int                    value;
        for (int k = 0; k < NUM_CHANNELS; k++) begin
            value = int'($signed(samples[k*SAMPLE_WIDTH +: SAMPLE_WIDTH]));
            value = value >>> shift;
            if (value > 3) begin
                value = 3;
            end else if (value < -4) begin
                value = -4;
            end
            result[k*SYM_WIDTH +: SYM_WIDTH] = value[SYM_WIDTH-1:0];
        end
        return result;
    endfunction

    function automatic logic [NUM_CHANNELS*SAMPLE_WIDTH-1:0] random_samples();
        return {$random(seed), $random(seed)};
    endfunction

    // drop words until the delivered one turns up
    task automatic search_sent(input logic [WORD_WIDTH-1:0] word);
        logic found;
        found = 1'b0;
        while (!found && (exp_q.size() != 0)) begin
            if (exp_q[0] == word) begin
                found = 1'b1;
            end
            void'(exp_q.pop_front());
        end
        if (!found) begin
            report_failure("delivered word is not a later member of the sent sequence");
        end
    endtask

    always @(negedge o_clk) begin
        if (!i_rst && (o_lane_valid != '0)) begin
            pulse_count++;
            if (strict_order) begin
                if (exp_q.size() == 0) begin
                    report_failure("lane pulse arrived with no word outstanding");
                end else begin
                    check_value("o_lane_valid", 32'(o_lane_valid),
                                32'(exp_q[0][WORD_WIDTH-1:SYMS_WIDTH]));
                    check_value("o_lane_syms", 32'(o_lane_syms),
                                32'(exp_q[0][SYMS_WIDTH-1:0]));
                    void'(exp_q.pop_front());
                end
            end else begin
                search_sent({o_lane_valid, o_lane_syms});
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired before the tests completed");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    task automatic write_reg(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] data);
        @(posedge i_clk);
        i_cfg_we    <= 1'b1;
        i_cfg_addr  <= addr;
        i_cfg_wdata <= data;
        @(posedge i_clk);
        i_cfg_we <= 1'b0;
        if (addr == ADDR_SHIFT) begin
            cur_shift = data[2:0];
        end
        if (addr == ADDR_LANE_MASK) begin
            cur_mask = data[NUM_VITERBIS-1:0];
        end
    endtask

    task automatic expect_reg(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] value);
        @(posedge i_clk);
        i_cfg_we   <= 1'b0;
        i_cfg_addr <= addr;
        @(negedge i_clk);
        check_value("o_cfg_rdata", 32'(o_cfg_rdata), 32'(value));
    endtask

    task automatic send_word(input logic [NUM_CHANNELS*SAMPLE_WIDTH-1:0] samples,
                             input logic [NUM_VITERBIS-1:0] tag);
        logic [NUM_VITERBIS-1:0] masked;
        masked = tag & cur_mask;
        @(posedge i_clk);
        i_valid   <= 1'b1;
        i_samples <= samples;
        i_tag     <= tag;
        if (masked != '0) begin
            exp_q.push_back({masked, ref_quantize(samples, int'(cur_shift))});
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge i_clk);
            i_valid <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge o_clk);
        end
    endtask

    // no pulse for longer than the crossing latency
    task automatic wait_quiet();
        int calm;
        calm = 0;
        while (calm < 8) begin
            @(negedge o_clk);
            if (o_lane_valid != '0) begin
                calm = 0;
            end else begin
                calm++;
            end
        end
    endtask

    task automatic readback_registers();
        expect_reg(ADDR_SHIFT, 8'h00);
        expect_reg(ADDR_LANE_MASK, CFG_DW'(LANE_MASK_RESET));
        expect_reg(ADDR_STATUS, 8'h00);
        write_reg(ADDR_SHIFT, 8'h05);
        expect_reg(ADDR_SHIFT, 8'h05);
        write_reg(ADDR_LANE_MASK, 8'h0A);
        expect_reg(ADDR_LANE_MASK, 8'h0A);
        expect_reg(2'd3, 8'h00);
        write_reg(ADDR_SHIFT, 8'h00);
        write_reg(ADDR_LANE_MASK, CFG_DW'(LANE_MASK_RESET));
    endtask

    task automatic sweep_quantization();
        logic [NUM_CHANNELS*SAMPLE_WIDTH-1:0] samples;
        for (int sh = 0; sh < 8; sh++) begin
            write_reg(ADDR_SHIFT, CFG_DW'(sh));
            for (int n = 0; n < QUANT_WORDS; n++) begin
                // extremes first, then random
                if (n == 0) begin
                    samples = 64'h7F80_7F80_7F80_7F80;
                end else if (n == 1) begin
                    samples = 64'h807F_807F_807F_807F;
                end else begin
                    samples = random_samples();
                end
                send_word(samples, 4'($random(seed)) | 4'h1);
                idle_cycles(1);
                wait_drained();
            end
        end
        write_reg(ADDR_SHIFT, 8'h00);
    endtask

    task automatic route_lane_masks();
        logic [NUM_VITERBIS-1:0] mask;
        for (int r = 0; r < MASK_ROUNDS; r++) begin
            mask = (r == 0) ? '0 : 4'($random(seed));
            write_reg(ADDR_LANE_MASK, CFG_DW'(mask));
            expect_reg(ADDR_LANE_MASK, CFG_DW'(mask));
            for (int n = 0; n < MASK_WORDS; n++) begin
                send_word(random_samples(), 4'($random(seed)));
                idle_cycles(2);
                wait_drained();
            end
        end
        wait_quiet();
        write_reg(ADDR_LANE_MASK, CFG_DW'(LANE_MASK_RESET));
    endtask

    task automatic stream_with_gaps();
        int gap;
        for (int n = 0; n < ORDER_WORDS; n++) begin
            send_word(random_samples(), 4'($random(seed)));
            gap = int'(2'($random(seed)));
            idle_cycles(gap);
        end
        idle_cycles(1);
        wait_quiet();
        expect_reg(ADDR_STATUS, 8'h00);
    endtask

    task automatic burst_overflow();
        strict_order = 1'b0;
        pulse_count  = 0;
        for (int n = 0; n < BURST_WORDS; n++) begin
            send_word(random_samples(), 4'($random(seed)) | 4'h1);
        end
        idle_cycles(1);
        wait_quiet();
        if (pulse_count < FIFO_DEPTH) begin
            report_failure("too few words delivered during the burst");
        end
        expect_reg(ADDR_STATUS, 8'h01);
        write_reg(ADDR_STATUS, 8'h01);
        expect_reg(ADDR_STATUS, 8'h00);
        // dropped words never arrive
        exp_q.delete();
        strict_order = 1'b1;
    endtask

    initial begin
        seed         = 35446;
        i_clk        = 1'b0;
        o_clk        = 1'b0;
        i_rst        = 1'b1;
        i_valid      = 1'b0;
        i_samples    = '0;
        i_tag        = '0;
        i_cfg_we     = 1'b0;
        i_cfg_addr   = '0;
        i_cfg_wdata  = '0;
        strict_order = 1'b1;
        pulse_count  = 0;
        cur_shift    = 3'd0;
        cur_mask     = LANE_MASK_RESET;

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;

        readback_registers();
        sweep_quantization();
        route_lane_masks();
        burst_overflow();
        stream_with_gaps();

        if (exp_q.size() != 0) begin
            report_failure("words were left undelivered at the end of the run");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* list.f */
verilog/symtag_pkg.sv
verilog/symtag_wr_if.sv
verilog/symtag_rd_if.sv
verilog/rx_cfg_regs.sv
verilog/symbol_quantizer.sv
verilog/symtag_fifo.sv
verilog/lane_router.sv
verilog/symtag_rx_top.sv
sim/symtag_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= symtag_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
